// File: include/spbus_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus widths, memory depth and memory latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SPBUS_DEFS_SVH
`define SPBUS_DEFS_SVH

// Width of one data word on the beat bus
`define SP_DATA_W 32

// Word address width, enough to cover every memory word
`define SP_ADDR_W 8

// Transaction id width carried on commands and responses
`define SP_ID_W 4

// Number of words in the shared memory
`define MEM_DEPTH 256

// Cycles from command acceptance to response at the memory target
`define MEM_LAT 4

`endif

// File: rtl/spbus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Beat bus types: beat kinds, command and response beats
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "spbus_defs.svh"

package spbus_pkg;

    // Kind of a command beat
    // A write opens with WADDR and always closes with WLAST
    typedef enum logic [1:0] {
        KIND_READ  = 2'b00,
        KIND_WADDR = 2'b01,
        KIND_WDATA = 2'b10,
        KIND_WLAST = 2'b11
    } beat_kind_t;

    // Kind of a response beat
    // NONE marks an idle slot and is never handed to a master
    typedef enum logic [1:0] {
        RSP_NONE  = 2'b00,
        RSP_RDATA = 2'b01,
        RSP_WACK  = 2'b10
    } rsp_kind_t;

    // Command beat, 46 bits
    // Address is meaningful on READ and WADDR, data on WDATA and WLAST
    typedef struct packed {
        beat_kind_t             kind;
        logic [`SP_ID_W-1:0]    id;
        logic [`SP_ADDR_W-1:0]  addr;
        logic [`SP_DATA_W-1:0]  data;
    } sp_cmd_t;

    // Response beat, 38 bits
    typedef struct packed {
        rsp_kind_t              kind;
        logic [`SP_ID_W-1:0]    id;
        logic [`SP_DATA_W-1:0]  data;
    } sp_rsp_t;

endpackage

// File: rtl/mem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory side types: port tag, tagged command and response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mem_pkg;

    import spbus_pkg::*;

    // Index of the master port a beat came from
    typedef logic port_t;

    // Command as seen by the memory, tagged with its source port
    typedef struct packed {
        port_t   port;
        sp_cmd_t cmd;
    } mem_cmd_t;

    // Response from the memory, the tag is copied from the command
    // so the arbiter can steer it back
    typedef struct packed {
        port_t   port;
        sp_rsp_t rsp;
    } mem_rsp_t;

endpackage

// File: rtl/stream_slice.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One-deep registered valid/ready slice
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module stream_slice
    import spbus_pkg::*;
#(
    parameter type payload_t = sp_cmd_t
) (
    input  logic     CLK,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    // Goes high one cycle after reset drops and keeps ready low until then
    logic live_q;

    // Accept when the single entry is empty or leaves in this cycle
    assign in_ready = live_q && (!out_valid || out_ready);

    always_ff @(posedge CLK) begin
        if (rst) begin
            live_q    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            live_q <= 1'b1;
            // Whenever the entry can move, the new valid is whatever arrives
            if (in_ready) begin
                out_valid <= in_valid;
            end
        end
    end

    // Payload only loads on a transfer
    always_ff @(posedge CLK) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

    // A stalled beat must not change under the consumer
    a_hold_data: assert property (@(posedge CLK) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: rtl/write_proxy.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write proxy: early write acknowledge, downstream ack filter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "spbus_defs.svh"

module write_proxy
    import spbus_pkg::*;
(
    input  logic    CLK,
    input  logic    rst,
    input  logic    up_cmd_valid,
    input  sp_cmd_t up_cmd,
    output logic    up_cmd_ready,
    output logic    up_rsp_valid,
    output sp_rsp_t up_rsp,
    input  logic    up_rsp_ready,
    output logic    dn_cmd_valid,
    output sp_cmd_t dn_cmd,
    input  logic    dn_cmd_ready,
    input  logic    dn_rsp_valid,
    input  sp_rsp_t dn_rsp,
    output logic    dn_rsp_ready
);

    // Id of the write currently being sent downstream
    logic [`SP_ID_W-1:0] wr_id;

    logic is_wlast;
    logic dn_rsp_busy;
    logic allow_last;
    logic local_ack;
    logic fwd_valid;

    assign is_wlast    = up_cmd_valid && (up_cmd.kind == KIND_WLAST);
    // Any real downstream response occupies the upstream response slot
    assign dn_rsp_busy = dn_rsp_valid && (dn_rsp.kind != RSP_NONE);
    // The last beat may only go when our ack has a free slot upstream
    assign allow_last  = up_rsp_ready && !dn_rsp_busy;

    // Command path is a straight pass except for the gated last beat
    assign dn_cmd       = up_cmd;
    assign dn_cmd_valid = is_wlast ? allow_last : up_cmd_valid;
    assign up_cmd_ready = is_wlast ? (dn_cmd_ready && allow_last) : dn_cmd_ready;

    // Local ack fires in the very cycle the last beat transfers
    assign local_ack = is_wlast && allow_last && dn_cmd_ready;

    // Only read data travels upward and memory acks end here
    assign fwd_valid    = dn_rsp_valid && (dn_rsp.kind == RSP_RDATA);
    assign up_rsp_valid = fwd_valid || local_ack;
    assign dn_rsp_ready = (dn_rsp.kind == RSP_RDATA) ? up_rsp_ready : 1'b1;

    always_comb begin
        if (local_ack) begin
            up_rsp.kind = RSP_WACK;
            up_rsp.id   = wr_id;
            up_rsp.data = '0;
        end else begin
            up_rsp = dn_rsp;
        end
    end

    // Capture the id as the address beat is taken
    always_ff @(posedge CLK) begin
        if (up_cmd_valid && up_cmd_ready && (up_cmd.kind == KIND_WADDR)) begin
            wr_id <= up_cmd.id;
        end
    end

    // Our ack and forwarded read data never share the upstream slot
    a_no_collide: assert property (@(posedge CLK) disable iff (rst)
        up_rsp_valid && (up_rsp.kind == RSP_WACK)
            |-> !(dn_rsp_valid && (dn_rsp.kind == RSP_RDATA)));

endmodule

// File: rtl/cmd_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-port round-robin command arbiter with burst lock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module cmd_arbiter
    import spbus_pkg::*;
    import mem_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic [1:0] p_cmd_valid,
    input  sp_cmd_t    p_cmd [2],
    output logic [1:0] p_cmd_ready,
    output logic [1:0] p_rsp_valid,
    output sp_rsp_t    p_rsp [2],
    input  logic [1:0] p_rsp_ready,
    output logic       mem_cmd_valid,
    output mem_cmd_t   mem_cmd,
    input  logic       mem_cmd_ready,
    input  logic       mem_rsp_valid,
    input  mem_rsp_t   mem_rsp,
    output logic       mem_rsp_ready
);

    // Port that wins a tie next time
    port_t rr_ptr;
    // Set between a granted WADDR and its WLAST
    logic  lock_valid;
    port_t lock_port;
    port_t gnt;
    logic  cmd_fire;

    // A locked burst owns the bus, otherwise the preferred port goes first
    always_comb begin
        if (lock_valid) begin
            gnt = lock_port;
        end else if (p_cmd_valid[rr_ptr]) begin
            gnt = rr_ptr;
        end else begin
            gnt = ~rr_ptr;
        end
    end

    assign mem_cmd_valid  = p_cmd_valid[gnt];
    assign mem_cmd.port   = gnt;
    assign mem_cmd.cmd    = p_cmd[gnt];
    assign p_cmd_ready[0] = mem_cmd_ready && (gnt == 1'b0);
    assign p_cmd_ready[1] = mem_cmd_ready && (gnt == 1'b1);
    assign cmd_fire       = mem_cmd_valid && mem_cmd_ready;

    always_ff @(posedge CLK) begin
        if (rst) begin
            rr_ptr     <= 1'b0;
            lock_valid <= 1'b0;
            lock_port  <= 1'b0;
        end else if (cmd_fire) begin
            if (mem_cmd.cmd.kind == KIND_WADDR) begin
                lock_valid <= 1'b1;
                lock_port  <= gnt;
            end
            // A read or a closed burst hands priority to the other port
            if ((mem_cmd.cmd.kind == KIND_READ) || (mem_cmd.cmd.kind == KIND_WLAST)) begin
                lock_valid <= 1'b0;
                rr_ptr     <= ~gnt;
            end
        end
    end

    // Responses go back to the port named in the tag
    assign p_rsp_valid[0] = mem_rsp_valid && (mem_rsp.port == 1'b0);
    assign p_rsp_valid[1] = mem_rsp_valid && (mem_rsp.port == 1'b1);
    assign p_rsp[0]       = mem_rsp.rsp;
    assign p_rsp[1]       = mem_rsp.rsp;
    assign mem_rsp_ready  = p_rsp_ready[mem_rsp.port];

    // The lock stays on its port until WLAST has gone through
    a_lock_stable: assert property (@(posedge CLK) disable iff (rst)
        lock_valid && !(cmd_fire && (mem_cmd.cmd.kind == KIND_WLAST))
            |=> lock_valid && (lock_port == $past(lock_port)));

endmodule

// File: rtl/mem_target.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word memory target with fixed response latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "spbus_defs.svh"

module mem_target
    import spbus_pkg::*;
    import mem_pkg::*;
(
    input  logic     CLK,
    input  logic     rst,
    input  logic     cmd_valid,
    input  mem_cmd_t cmd,
    output logic     cmd_ready,
    output logic     rsp_valid,
    output mem_rsp_t rsp,
    input  logic     rsp_ready
);

    logic [`SP_DATA_W-1:0] mem_q [`MEM_DEPTH];
    // Next word to be written inside the open burst
    logic [`SP_ADDR_W-1:0] wr_addr;

    // Delay line whose last stage drives the output
    logic [`MEM_LAT-1:0] stg_valid;
    mem_rsp_t            stg_rsp [`MEM_LAT];

    logic     stall;
    logic     cmd_fire;
    logic     is_data;
    logic     makes_rsp;
    mem_rsp_t new_rsp;

    assign rsp_valid = stg_valid[`MEM_LAT-1];
    assign rsp       = stg_rsp[`MEM_LAT-1];
    // A waiting output freezes the whole line, so nothing new may enter
    assign stall     = rsp_valid && !rsp_ready;
    assign cmd_ready = !stall;
    assign cmd_fire  = cmd_valid && cmd_ready;

    assign is_data   = (cmd.cmd.kind == KIND_WDATA) || (cmd.cmd.kind == KIND_WLAST);
    // Reads return data and the last write beat returns an ack
    assign makes_rsp = (cmd.cmd.kind == KIND_READ) || (cmd.cmd.kind == KIND_WLAST);

    // Read data is taken at acceptance, so earlier writes are visible
    always_comb begin
        new_rsp.port    = cmd.port;
        new_rsp.rsp.id  = cmd.cmd.id;
        if (cmd.cmd.kind == KIND_READ) begin
            new_rsp.rsp.kind = RSP_RDATA;
            new_rsp.rsp.data = mem_q[cmd.cmd.addr];
        end else begin
            new_rsp.rsp.kind = RSP_WACK;
            new_rsp.rsp.data = '0;
        end
    end

    // The address beat loads the pointer and every data beat writes and steps it
    always_ff @(posedge CLK) begin
        if (cmd_fire && (cmd.cmd.kind == KIND_WADDR)) begin
            wr_addr <= cmd.cmd.addr;
        end else if (cmd_fire && is_data) begin
            mem_q[wr_addr] <= cmd.cmd.data;
            wr_addr        <= wr_addr + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            stg_valid <= '0;
        end else if (!stall) begin
            stg_valid <= {stg_valid[`MEM_LAT-2:0], cmd_fire && makes_rsp};
        end
    end

    always_ff @(posedge CLK) begin
        if (!stall) begin
            stg_rsp[0] <= new_rsp;
            for (int i = 1; i < `MEM_LAT; i++) begin
                stg_rsp[i] <= stg_rsp[i-1];
            end
        end
    end

endmodule

// File: rtl/post_write_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Posted-write subsystem: slices, proxies, arbiter, memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module post_write_top
    import spbus_pkg::*;
    import mem_pkg::*;
(
    input  logic       CLK,
    input  logic       rst,
    input  logic [1:0] m_cmd_valid,
    input  sp_cmd_t    m_cmd [2],
    output wire  [1:0] m_cmd_ready,
    output wire  [1:0] m_rsp_valid,
    output wire sp_rsp_t m_rsp [2],
    input  logic [1:0] m_rsp_ready
);

    // Slice to proxy, upstream side of each proxy
    wire [1:0]    sl_cmd_valid, sl_cmd_ready;
    wire sp_cmd_t sl_cmd [2];
    wire [1:0]    px_rsp_valid, px_rsp_ready;
    wire sp_rsp_t px_rsp [2];
    // Proxy to arbiter
    wire [1:0]    ar_cmd_valid, ar_cmd_ready;
    wire sp_cmd_t ar_cmd [2];
    wire [1:0]    ar_rsp_valid, ar_rsp_ready;
    wire sp_rsp_t ar_rsp [2];
    // Arbiter to memory
    wire          mm_cmd_valid, mm_cmd_ready;
    wire mem_cmd_t mm_cmd;
    wire          mm_rsp_valid, mm_rsp_ready;
    wire mem_rsp_t mm_rsp;

    for (genvar i = 0; i < 2; i++) begin : g_port
        stream_slice #(.payload_t(sp_cmd_t)) u_cmd_slice (
            .CLK(CLK), .rst(rst),
            .in_valid(m_cmd_valid[i]), .in_data(m_cmd[i]), .in_ready(m_cmd_ready[i]),
            .out_valid(sl_cmd_valid[i]), .out_data(sl_cmd[i]), .out_ready(sl_cmd_ready[i])
        );

        write_proxy u_proxy (
            .CLK(CLK), .rst(rst),
            .up_cmd_valid(sl_cmd_valid[i]), .up_cmd(sl_cmd[i]), .up_cmd_ready(sl_cmd_ready[i]),
            .up_rsp_valid(px_rsp_valid[i]), .up_rsp(px_rsp[i]), .up_rsp_ready(px_rsp_ready[i]),
            .dn_cmd_valid(ar_cmd_valid[i]), .dn_cmd(ar_cmd[i]), .dn_cmd_ready(ar_cmd_ready[i]),
            .dn_rsp_valid(ar_rsp_valid[i]), .dn_rsp(ar_rsp[i]), .dn_rsp_ready(ar_rsp_ready[i])
        );

        stream_slice #(.payload_t(sp_rsp_t)) u_rsp_slice (
            .CLK(CLK), .rst(rst),
            .in_valid(px_rsp_valid[i]), .in_data(px_rsp[i]), .in_ready(px_rsp_ready[i]),
            .out_valid(m_rsp_valid[i]), .out_data(m_rsp[i]), .out_ready(m_rsp_ready[i])
        );
    end

    cmd_arbiter u_arb (
        .CLK(CLK), .rst(rst),
        .p_cmd_valid(ar_cmd_valid), .p_cmd(ar_cmd), .p_cmd_ready(ar_cmd_ready),
        .p_rsp_valid(ar_rsp_valid), .p_rsp(ar_rsp), .p_rsp_ready(ar_rsp_ready),
        .mem_cmd_valid(mm_cmd_valid), .mem_cmd(mm_cmd), .mem_cmd_ready(mm_cmd_ready),
        .mem_rsp_valid(mm_rsp_valid), .mem_rsp(mm_rsp), .mem_rsp_ready(mm_rsp_ready)
    );

    mem_target u_mem (
        .CLK(CLK), .rst(rst),
        .cmd_valid(mm_cmd_valid), .cmd(mm_cmd), .cmd_ready(mm_cmd_ready),
        .rsp_valid(mm_rsp_valid), .rsp(mm_rsp), .rsp_ready(mm_rsp_ready)
    );

endmodule

// File: tb/tb_clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock (10 ns period) and synchronous reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_clk_gen (
    output logic CLK,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // Reset covers the first 16 rising edges and drops right after the last one
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge CLK);
        rst <= 1'b0;
    end

endmodule

// File: tb/post_write_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Posted-write testbench: stimulus table, reference memory,
// LFSR response stalls, compare tasks, cycle watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "spbus_defs.svh"

module post_write_tb
    import spbus_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_ENT = 19;

    // One row of the stimulus table
    typedef struct packed {
        logic                       port;
        logic [2:0]                 len;    // 0 for a read, else the number of write words
        logic                       join_after;
        logic                       stall;
        logic [`SP_ID_W-1:0]        id;
        logic [`SP_ADDR_W-1:0]      addr;
        rsp_kind_t                  exp_kind;
        logic [`SP_ID_W-1:0]        exp_id;
        logic [3:0][`SP_DATA_W-1:0] words;
    } entry_t;

    // A request still waiting for its response at a port
    typedef struct packed {
        logic [7:0]                 idx;
        rsp_kind_t                  kind;
        logic [`SP_ID_W-1:0]        id;
        logic [`SP_ADDR_W-1:0]      addr;
        logic [2:0]                 len;
        logic [3:0][`SP_DATA_W-1:0] words;
    } pend_t;

    logic       CLK;
    logic       rst;
    logic [1:0] m_cmd_valid;
    sp_cmd_t    m_cmd [2];
    logic [1:0] m_cmd_ready;
    logic [1:0] m_rsp_valid;
    sp_rsp_t    m_rsp [2];
    logic [1:0] m_rsp_ready;

    entry_t                tbl [N_ENT];
    sp_cmd_t               cmd_q [2][$];
    pend_t                 pend_q [2][$];
    logic [`SP_DATA_W-1:0] ref_mem [`MEM_DEPTH];
    logic [31:0]           lfsr;
    logic                  stall_on;
    int                    wr_issued [2];
    int                    wack_seen [2];
    int                    checks;
    int                    errors;
    int                    limit;
    int                    cycles;

    tb_clk_gen u_clk (.CLK(CLK), .rst(rst));

    post_write_top DUT (
        .CLK(CLK), .rst(rst),
        .m_cmd_valid(m_cmd_valid), .m_cmd(m_cmd), .m_cmd_ready(m_cmd_ready),
        .m_rsp_valid(m_rsp_valid), .m_rsp(m_rsp), .m_rsp_ready(m_rsp_ready)
    );

    // Galois form, shifting right with taps 32, 30, 26 and 25
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    task automatic draw_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];
    endtask

    function automatic entry_t mk(input logic port, input logic [2:0] len,
                                  input logic join_after, input logic stall,
                                  input logic [`SP_ID_W-1:0] id,
                                  input logic [`SP_ADDR_W-1:0] addr,
                                  input rsp_kind_t exp_kind,
                                  input logic [`SP_ID_W-1:0] exp_id,
                                  input logic [4*`SP_DATA_W-1:0] words);
        entry_t e;
        e.port       = port;
        e.len        = len;
        e.join_after = join_after;
        e.stall      = stall;
        e.id         = id;
        e.addr       = addr;
        e.exp_kind   = exp_kind;
        e.exp_id     = exp_id;
        e.words      = words;
        return e;
    endfunction

    // Columns: port, len, join, stall, id, addr, expected kind, expected id, words
    task automatic fill_table();
        // Write on port 0 and read every word back
        tbl[0]  = mk(1'b0, 3'd3, 1'b1, 1'b0, 4'h1, 8'h10, RSP_WACK, 4'h1,
                     {32'h0, 32'hc0de_0003, 32'hc0de_0002, 32'hc0de_0001});
        tbl[1]  = mk(1'b0, 3'd0, 1'b0, 1'b0, 4'h2, 8'h10, RSP_RDATA, 4'h2, '0);
        tbl[2]  = mk(1'b0, 3'd0, 1'b0, 1'b0, 4'h3, 8'h11, RSP_RDATA, 4'h3, '0);
        tbl[3]  = mk(1'b0, 3'd0, 1'b1, 1'b0, 4'h4, 8'h12, RSP_RDATA, 4'h4, '0);
        // Bursts of four from both ports at once onto the same words
        tbl[4]  = mk(1'b0, 3'd4, 1'b0, 1'b0, 4'h5, 8'h40, RSP_WACK, 4'h5,
                     {32'ha000_0003, 32'ha000_0002, 32'ha000_0001, 32'ha000_0000});
        tbl[5]  = mk(1'b1, 3'd4, 1'b1, 1'b0, 4'h6, 8'h40, RSP_WACK, 4'h6,
                     {32'hb000_0003, 32'hb000_0002, 32'hb000_0001, 32'hb000_0000});
        tbl[6]  = mk(1'b1, 3'd0, 1'b0, 1'b0, 4'h7, 8'h40, RSP_RDATA, 4'h7, '0);
        tbl[7]  = mk(1'b1, 3'd0, 1'b0, 1'b0, 4'h8, 8'h41, RSP_RDATA, 4'h8, '0);
        tbl[8]  = mk(1'b0, 3'd0, 1'b0, 1'b0, 4'h9, 8'h42, RSP_RDATA, 4'h9, '0);
        tbl[9]  = mk(1'b0, 3'd0, 1'b1, 1'b0, 4'ha, 8'h43, RSP_RDATA, 4'ha, '0);
        // Random response stalls on both ports
        tbl[10] = mk(1'b1, 3'd2, 1'b1, 1'b1, 4'h1, 8'h80, RSP_WACK, 4'h1,
                     {32'h0, 32'h0, 32'h5a5a_0081, 32'h5a5a_0080});
        tbl[11] = mk(1'b0, 3'd0, 1'b0, 1'b1, 4'hb, 8'h80, RSP_RDATA, 4'hb, '0);
        tbl[12] = mk(1'b1, 3'd0, 1'b0, 1'b1, 4'h2, 8'h81, RSP_RDATA, 4'h2, '0);
        tbl[13] = mk(1'b0, 3'd0, 1'b0, 1'b1, 4'hc, 8'h41, RSP_RDATA, 4'hc, '0);
        tbl[14] = mk(1'b1, 3'd0, 1'b1, 1'b1, 4'h3, 8'h12, RSP_RDATA, 4'h3, '0);
        // Read right behind a write to the same word on the same port
        tbl[15] = mk(1'b1, 3'd1, 1'b0, 1'b0, 4'h4, 8'h90, RSP_WACK, 4'h4,
                     {32'h0, 32'h0, 32'h0, 32'h5eed_0001});
        tbl[16] = mk(1'b1, 3'd0, 1'b1, 1'b0, 4'h5, 8'h90, RSP_RDATA, 4'h5, '0);
        tbl[17] = mk(1'b0, 3'd2, 1'b0, 1'b0, 4'hd, 8'h94, RSP_WACK, 4'hd,
                     {32'h0, 32'h0, 32'h5eed_0095, 32'h5eed_0094});
        tbl[18] = mk(1'b0, 3'd0, 1'b1, 1'b0, 4'he, 8'h95, RSP_RDATA, 4'he, '0);
    endtask

    // Cycle budget for the whole run, four times the sum over all rows
    function automatic int budget();
        int sum;
        sum = 0;
        for (int i = 0; i < N_ENT; i++) begin
            sum += ((tbl[i].len == 3'd0) ? 1 : tbl[i].len + 1) + `MEM_LAT + 20;
        end
        return sum * 4;
    endfunction

    task automatic check_rsp(input string name, input sp_rsp_t got, input sp_rsp_t exp);
        logic bad;
        checks++;
        bad = (got.kind != exp.kind) || (got.id != exp.id);
        // Acks carry no data worth comparing
        if ((exp.kind == RSP_RDATA) && (got.data != exp.data)) begin
            bad = 1'b1;
        end
        if (bad) begin
            errors++;
            $display("ERROR %s: got kind %h id %h data %h, expected kind %h id %h data %h",
                     name, got.kind, got.id, got.data, exp.kind, exp.id, exp.data);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Turn a table row into command beats and one pending response
    task automatic queue_entry(input entry_t e, input int idx);
        sp_cmd_t c;
        pend_t   pd;
        c        = '0;
        c.id     = e.id;
        c.addr   = e.addr;
        pd       = '0;
        pd.idx   = idx[7:0];
        pd.kind  = e.exp_kind;
        pd.id    = e.exp_id;
        pd.addr  = e.addr;
        pd.len   = e.len;
        pd.words = e.words;
        stall_on = e.stall;
        pend_q[e.port].push_back(pd);
        if (e.len == 3'd0) begin
            c.kind = KIND_READ;
            cmd_q[e.port].push_back(c);
        end else begin
            wr_issued[e.port]++;
            c.kind = KIND_WADDR;
            cmd_q[e.port].push_back(c);
            c.addr = '0;
            for (int i = 0; i < e.len; i++) begin
                c.kind = (i == e.len - 1) ? KIND_WLAST : KIND_WDATA;
                c.data = e.words[i];
                cmd_q[e.port].push_back(c);
            end
        end
    endtask

    // Beats go out on the falling edge and stay until ready was seen
    task automatic drive_port(input int p);
        m_cmd_valid[p] = 1'b0;
        m_cmd[p]       = '0;
        forever begin
            @(negedge CLK);
            if (!rst && (cmd_q[p].size() > 0)) begin
                m_cmd_valid[p] = 1'b1;
                m_cmd[p]       = cmd_q[p][0];
                #1;
                // Ready has settled here and holds until the rising edge
                if (m_cmd_ready[p]) begin
                    void'(cmd_q[p].pop_front());
                end
            end else begin
                m_cmd_valid[p] = 1'b0;
            end
        end
    endtask

    // Match a response to its request by id and predict it
    task automatic take_rsp(input int p, input sp_rsp_t r);
        pend_t   pd;
        sp_rsp_t exp;
        int      hit;
        hit = -1;
        for (int k = 0; k < pend_q[p].size(); k++) begin
            if ((hit < 0) && (pend_q[p][k].id == r.id)) begin
                hit = k;
            end
        end
        if (r.kind == RSP_WACK) begin
            wack_seen[p]++;
        end
        if (hit < 0) begin
            errors++;
            $display("port %0d returned a response with id %h that no request waits for",
                     p, r.id);
        end else begin
            pd = pend_q[p][hit];
            pend_q[p].delete(hit);
            exp.kind = pd.kind;
            exp.id   = pd.id;
            exp.data = (pd.kind == RSP_RDATA) ? ref_mem[pd.addr] : '0;
            check_rsp($sformatf("m_rsp[%0d]", p), r, exp);
            // Bursts land in the reference in the order their acks return
            if (pd.kind == RSP_WACK) begin
                for (int i = 0; i < pd.len; i++) begin
                    ref_mem[pd.addr + i] = pd.words[i];
                end
            end
            $display("entry %0d: port %0d %s id %h done", pd.idx, p,
                     (pd.kind == RSP_WACK) ? "write" : "read", pd.id);
        end
    endtask

    // Response ready is drawn on the falling edge, transfers seen 1 ns later
    task automatic watch_rsp();
        logic a;
        logic b;
        m_rsp_ready = 2'b11;
        forever begin
            @(negedge CLK);
            for (int p = 0; p < 2; p++) begin
                if (stall_on) begin
                    draw_bit(a);
                    draw_bit(b);
                    m_rsp_ready[p] = a | b;
                end else begin
                    m_rsp_ready[p] = 1'b1;
                end
            end
            #1;
            for (int p = 0; p < 2; p++) begin
                if (m_rsp_valid[p] && m_rsp_ready[p]) begin
                    take_rsp(p, m_rsp[p]);
                end
            end
        end
    endtask

    task automatic wait_drain();
        while ((cmd_q[0].size() + cmd_q[1].size() + pend_q[0].size()
                + pend_q[1].size()) != 0) begin
            @(negedge CLK);
            #2;
        end
    endtask

    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int busy;
        busy         = 0;
        checks       = 0;
        errors       = 0;
        stall_on     = 1'b0;
        lfsr         = 32'h2aa73e8e;
        wr_issued[0] = 0;
        wr_issued[1] = 0;
        wack_seen[0] = 0;
        wack_seen[1] = 0;
        fill_table();
        limit = budget();
        fork
            drive_port(0);
            drive_port(1);
            watch_rsp();
        join_none
        @(negedge CLK);
        while (rst) begin
            @(negedge CLK);
        end
        // No response may appear before any command was given
        repeat (8) begin
            @(negedge CLK);
            #2;
            if (m_rsp_valid != 2'b00) begin
                busy++;
            end
        end
        check_count("m_rsp_valid busy cycles after reset", busy, 0);
        $display("idle after reset: %0d busy response cycles", busy);
        for (int i = 0; i < N_ENT; i++) begin
            queue_entry(tbl[i], i);
            if (tbl[i].join_after) begin
                wait_drain();
            end
        end
        wait_drain();
        // Quiet window in which a repeated ack would still show up
        repeat (`MEM_LAT + 10) @(negedge CLK);
        check_count("port 0 write acks", wack_seen[0], wr_issued[0]);
        check_count("port 1 write acks", wack_seen[1], wr_issued[1]);
        $display("acks: port 0 %0d of %0d, port 1 %0d of %0d",
                 wack_seen[0], wr_issued[0], wack_seen[1], wr_issued[1]);
        $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
rtl/spbus_pkg.sv
rtl/mem_pkg.sv
rtl/stream_slice.sv
rtl/write_proxy.sv
rtl/cmd_arbiter.sv
rtl/mem_target.sv
rtl/post_write_top.sv
tb/tb_clk_gen.sv
tb/post_write_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then judge the run from its log
verilator --binary --timing --assert -Wno-fatal --top-module post_write_tb \
    -f filelist.f -o post_write_sim > build.log 2>&1 \
    && ./obj_dir/post_write_sim > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
